// File: list.f
+incdir+logic
logic/vga_pkg.sv
logic/line_fsm.sv
logic/video_timing.sv
logic/pixel_coords.sv
logic/video_out.sv
logic/vga_core.sv
dv/tb_clock.sv
dv/vga_properties.sv
dv/tb_vga.sv

// File: Makefile
TOP := tb_vga

.PHONY: compile run clean

compile:
	verilator --binary --timing --assert -Wno-fatal -f list.f --top-module $(TOP)

run: compile
	@out=$$(./obj_dir/V$(TOP) +verilator+error+limit+100); \
	echo "$$out"; \
	echo "$$out" | grep -q "Simulation PASSED"

clean:
	rm -rf obj_dir

// File: dv/tb_vga.sv
`timescale 1ns/1ps

`include "vga_cfg.svh"

module tb_vga;

    typedef struct {
        vga_pkg::timing_t hs, hb, ha, hf;  // Horizontal lengths in pixels
        vga_pkg::timing_t vs, vb, va, vf;  // Vertical lengths in lines
        logic             hp, vp;          // Sync polarities
        int               frames;          // Frames to run
        bit               rand_en;         // Random gaps in enable
        int               empty_pct;       // Chance of an empty FIFO per tick
    } row_t;

    localparam int NUM_ROWS = 4;

    logic clk, por_n, soft_rstn, rstn;
    logic enable, h_polarity, v_polarity, fifo_empty;
    logic de, h_sync, v_sync, line_end, frame_end;
    vga_pkg::timing_t h_sync_len, h_back_len, h_active_len, h_front_len;
    vga_pkg::timing_t v_sync_len, v_back_len, v_active_len, v_front_len;
    vga_pkg::pixel_t  data_in, data_out;
    vga_pkg::coord_t  x, y;

    row_t            rows [NUM_ROWS];
    vga_pkg::pixel_t fifo_head;            // Head pixel of the FIFO model
    integer          seed;
    int              checks, errors, cycle_limit;

    tb_clock u_clock (.clk(clk), .rstn(por_n));
    assign rstn = por_n & soft_rstn;       // Power-on reset or reset between rows

    vga_core i_dut (.*);

    // ==================================================
    // Compare tasks and reference helpers
    // ==================================================
    task automatic check_level(input string what, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("** Error @ %0t ns: %s is %b, expected %b", $time, what, got, exp);
        end
    endtask

    task automatic check_pixel(input string what, input vga_pkg::pixel_t got,
                               input vga_pkg::pixel_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("** Error @ %0t ns: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_coord(input string what, input vga_pkg::coord_t got,
                               input vga_pkg::coord_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("** Error @ %0t ns: %s is %0d, expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic check_count(input string what, input int got, input int exp);
        checks++;
        if (got != exp) begin
            errors++;
            $display("** Error @ %0t ns: %s count %0d, expected %0d", $time, what, got, exp);
        end
    endtask

    function automatic int axis_total(input vga_pkg::timing_t a, input vga_pkg::timing_t b,
                                      input vga_pkg::timing_t c, input vga_pkg::timing_t d);
        return int'(a) + int'(b) + int'(c) + int'(d);
    endfunction

    // Phase from the position inside one period
    function automatic vga_pkg::phase_e phase_at(input int pos, input int s, input int b,
                                                 input int a);
        if (pos < s)              return vga_pkg::SYN;
        else if (pos < s + b)     return vga_pkg::BCP;
        else if (pos < s + b + a) return vga_pkg::ACT;
        else                      return vga_pkg::FRP;
    endfunction

    // ==================================================
    // Reset with a new timing row
    // ==================================================
    task automatic apply_reset(input row_t r);
        @(posedge clk);
        soft_rstn    <= 1'b0;
        enable       <= 1'b0;
        fifo_empty   <= 1'b0;
        h_sync_len   <= r.hs;
        h_back_len   <= r.hb;
        h_active_len <= r.ha;
        h_front_len  <= r.hf;
        v_sync_len   <= r.vs;
        v_back_len   <= r.vb;
        v_active_len <= r.va;
        v_front_len  <= r.vf;
        h_polarity   <= r.hp;
        v_polarity   <= r.vp;
        repeat (3) @(posedge clk);         // Lets the syncs pick up the new polarity
        @(negedge clk);
        check_level("de in reset", de, 1'b0);
        check_level("line_end in reset", line_end, 1'b0);
        check_level("frame_end in reset", frame_end, 1'b0);
        check_pixel("data_out in reset", data_out, `VGA_BLANK_COLOR);
        check_level("h_sync in reset", h_sync, r.hp);  // Inactive level
        check_level("v_sync in reset", v_sync, r.vp);
        @(posedge clk);
        soft_rstn <= 1'b1;
    endtask

    // ==================================================
    // One row against the reference model
    // ==================================================
    task automatic run_row(input int idx);
        row_t            r;
        int              h_tot, v_tot, h_pos, v_pos, rnd;
        int              frames_done, line_cnt, de_cnt, err_start;
        bit              en_now, empty_now;
        vga_pkg::phase_e h_ph, v_ph;
        logic            exp_de, exp_le, exp_fe, exp_hs_q, exp_vs_q;
        vga_pkg::pixel_t exp_pix_q;
        vga_pkg::coord_t exp_x, exp_y;
        r = rows[idx];
        err_start = errors;
        apply_reset(r);
        h_tot = axis_total(r.hs, r.hb, r.ha, r.hf);
        v_tot = axis_total(r.vs, r.vb, r.va, r.vf);
        h_pos = 0;                         // Both axes start at the first SYN tick
        v_pos = 0;
        frames_done = 0;
        line_cnt = 0;
        de_cnt = 0;
        exp_hs_q = r.hp;                   // Registered outputs after reset
        exp_vs_q = r.vp;
        exp_pix_q = `VGA_BLANK_COLOR;
        while (frames_done < r.frames) begin
            @(posedge clk);
            rnd = $random(seed);
            en_now = r.rand_en ? rnd[0] : 1'b1;
            rnd = $random(seed);
            empty_now = ((rnd & 32'h7fff_ffff) % 100) < r.empty_pct;
            enable     <= en_now;
            fifo_empty <= empty_now;
            data_in    <= fifo_head;
            @(negedge clk);                // Outputs have settled by the falling edge
            h_ph = phase_at(h_pos, int'(r.hs), int'(r.hb), int'(r.ha));
            v_ph = phase_at(v_pos, int'(r.vs), int'(r.vb), int'(r.va));
            exp_de = (h_ph == vga_pkg::ACT) && (v_ph == vga_pkg::ACT);
            exp_le = en_now && (h_pos == h_tot - 1);
            exp_fe = exp_le && (v_pos == v_tot - 1);
            check_level("de", de, exp_de);
            check_level("line_end", line_end, exp_le);
            check_level("frame_end", frame_end, exp_fe);
            check_level("h_sync", h_sync, exp_hs_q);    // Holds through gaps
            check_level("v_sync", v_sync, exp_vs_q);
            check_pixel("data_out", data_out, exp_pix_q);
            if (exp_de) begin
                // Column in the active area, frozen through gaps
                exp_x = vga_pkg::coord_t'(h_pos - int'(r.hs) - int'(r.hb));
                exp_y = vga_pkg::coord_t'(v_pos);         // Line index in the frame
                check_coord("x", x, exp_x);
                check_coord("y", y, exp_y);
            end
            if (en_now) begin
                if (de) de_cnt++;
                exp_hs_q = (h_ph == vga_pkg::SYN) ^ r.hp;
                exp_vs_q = (v_ph == vga_pkg::SYN) ^ r.vp;
                if (!exp_de)        exp_pix_q = `VGA_BLANK_COLOR;
                else if (empty_now) exp_pix_q = `VGA_UNDERRUN_COLOR;
                else                exp_pix_q = fifo_head;
                if (de && !empty_now) fifo_head = fifo_head + 1'b1;  // FIFO pop
                if (line_end) line_cnt++;
                if (exp_fe) begin
                    check_count("line_end", line_cnt, v_tot);
                    check_count("de", de_cnt, int'(r.ha) * int'(r.va));
                    frames_done++;
                    line_cnt = 0;
                    de_cnt = 0;
                end
                if (exp_le) v_pos = (v_pos == v_tot - 1) ? 0 : v_pos + 1;
                h_pos = (h_pos == h_tot - 1) ? 0 : h_pos + 1;
            end
        end
        $display("Test %0d finished: %0d frames of %0dx%0d, %0d errors",
                 idx, frames_done, h_tot, v_tot, errors - err_start);
    endtask

    // ==================================================
    // Main sequence and watchdog
    // ==================================================
    initial begin : main
        seed = 32'h328a;
        checks = 0;
        errors = 0;
        soft_rstn = 1'b1;
        enable = 1'b0;
        fifo_empty = 1'b0;
        data_in = '0;
        fifo_head = 12'h001;
        {h_polarity, v_polarity} = 2'b00;
        {h_sync_len, h_back_len, h_active_len, h_front_len} = {4{12'd1}};
        {v_sync_len, v_back_len, v_active_len, v_front_len} = {4{12'd1}};
        // hs hb ha hf, vs vb va vf, hp vp, frames, random enable, empty %
        rows[0] = '{2, 3, 8, 2, 1, 2, 4, 1, 1'b0, 1'b0, 2, 1'b0, 0};
        rows[1] = '{2, 3, 8, 2, 1, 2, 4, 1, 1'b1, 1'b1, 2, 1'b1, 30};
        rows[2] = '{1, 1, 5, 1, 2, 1, 3, 2, 1'b1, 1'b0, 2, 1'b0, 50};
        rows[3] = '{3, 2, 6, 1, 1, 1, 2, 1, 1'b0, 1'b1, 3, 1'b1, 10};
        cycle_limit = 100;
        foreach (rows[i]) begin
            cycle_limit += rows[i].frames * 4 *
                           axis_total(rows[i].hs, rows[i].hb, rows[i].ha, rows[i].hf) *
                           axis_total(rows[i].vs, rows[i].vb, rows[i].va, rows[i].vf);
        end
        wait (por_n === 1'b1);
        for (int i = 0; i < NUM_ROWS; i++) run_row(i);
        errors += i_dut.u_props.fail_cnt;  // Bound assertion failures
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

    initial begin : watchdog
        int cycles;
        cycles = 0;
        wait (cycle_limit > 0);
        while (cycles < cycle_limit) begin
            @(posedge clk);
            cycles++;
        end
        $display("Timeout: the tests did not finish within %0d clock cycles", cycle_limit);
        $display("Simulation FAILED");
        $finish;
    end

endmodule

// File: dv/vga_properties.sv
`timescale 1ns/1ps

// Protocol checks on the raster generator top level
module vga_properties (
    input logic clk,
    input logic rstn,
    input logic enable,
    input logic de,
    input logic line_end,
    input logic frame_end,
    input logic h_sync_raw,                // Sync with polarity applied
    input logic v_sync_raw,
    input logic h_polarity,
    input logic v_polarity
);

    int fail_cnt = 0;                      // Failed assertions so far

    // Frame end is always the last line end of the frame
    a_frame_on_line: assert property (@(posedge clk) disable iff (!rstn)
        frame_end |-> line_end)
        else begin
            fail_cnt++;
            $error("frame_end seen without line_end");
        end

    // Raw sync XOR polarity gives the SYN phase of each axis
    a_de_off_in_sync: assert property (@(posedge clk) disable iff (!rstn)
        de |-> !(h_sync_raw ^ h_polarity) && !(v_sync_raw ^ v_polarity))
        else begin
            fail_cnt++;
            $error("de high during a sync phase");
        end

    a_line_end_single: assert property (@(posedge clk) disable iff (!rstn)
        line_end |=> !(enable && line_end))
        else begin
            fail_cnt++;
            $error("line_end longer than one tick");
        end

endmodule

bind vga_core vga_properties u_props (
    .clk(clk), .rstn(rstn), .enable(enable), .de(de),
    .line_end(line_end), .frame_end(frame_end),
    .h_sync_raw(h_sync_raw), .v_sync_raw(v_sync_raw),
    .h_polarity(h_polarity), .v_polarity(v_polarity)
);

// File: dv/tb_clock.sv
`timescale 1ns/1ps

// Free-running testbench clock and power-on reset
module tb_clock (
    output logic clk,
    output logic rstn
);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;             // 8 ns period
    end

    initial begin
        rstn = 1'b0;
        repeat (5) @(posedge clk);         // Held low for 5 cycles
        rstn <= 1'b1;
    end

endmodule

// File: logic/vga_core.sv
`timescale 1ns/1ps

// Top level of the raster generator
module vga_core (
    input  logic             clk,
    input  logic             rstn,
    input  logic             enable,       // Pixel tick
    input  vga_pkg::timing_t h_sync_len,
    input  vga_pkg::timing_t h_back_len,
    input  vga_pkg::timing_t h_active_len,
    input  vga_pkg::timing_t h_front_len,
    input  logic             h_polarity,
    input  vga_pkg::timing_t v_sync_len,
    input  vga_pkg::timing_t v_back_len,
    input  vga_pkg::timing_t v_active_len,
    input  vga_pkg::timing_t v_front_len,
    input  logic             v_polarity,
    input  vga_pkg::pixel_t  data_in,      // FIFO head
    input  logic             fifo_empty,
    output logic             de,           // FIFO read request
    output vga_pkg::pixel_t  data_out,
    output logic             h_sync,
    output logic             v_sync,
    output logic             line_end,
    output logic             frame_end,
    output vga_pkg::coord_t  x,
    output vga_pkg::coord_t  y
);

    logic h_sync_raw, v_sync_raw;          // Unregistered syncs

    // ==================================================
    // Timing, coordinates, output stage
    // ==================================================
    video_timing u_timing (
        .clk(clk), .rstn(rstn), .enable(enable),
        .h_sync_len(h_sync_len), .h_back_len(h_back_len),
        .h_active_len(h_active_len), .h_front_len(h_front_len),
        .v_sync_len(v_sync_len), .v_back_len(v_back_len),
        .v_active_len(v_active_len), .v_front_len(v_front_len),
        .h_polarity(h_polarity), .v_polarity(v_polarity),
        .de(de), .line_end(line_end), .frame_end(frame_end),
        .h_sync_raw(h_sync_raw), .v_sync_raw(v_sync_raw)
    );

    pixel_coords u_coords (
        .clk(clk), .rstn(rstn), .enable(enable),
        .de(de), .line_end(line_end), .frame_end(frame_end),
        .x(x), .y(y)
    );

    video_out u_out (
        .clk(clk), .rstn(rstn), .enable(enable),
        .de(de), .fifo_empty(fifo_empty),
        .h_sync_raw(h_sync_raw), .v_sync_raw(v_sync_raw),
        .h_polarity(h_polarity), .v_polarity(v_polarity),
        .data_in(data_in), .data_out(data_out),
        .h_sync(h_sync), .v_sync(v_sync)
    );

endmodule

// File: logic/video_out.sv
`timescale 1ns/1ps

`include "vga_cfg.svh"

// Pixel source selection and the registered output stage
module video_out (
    input  logic            clk,
    input  logic            rstn,
    input  logic            enable,        // Pixel tick
    input  logic            de,            // Pixel requested in this tick
    input  logic            fifo_empty,    // FIFO has no head pixel
    input  logic            h_sync_raw,    // Sync levels from the timing stage
    input  logic            v_sync_raw,
    input  logic            h_polarity,    // Inactive sync levels
    input  logic            v_polarity,
    input  vga_pkg::pixel_t data_in,       // Head pixel of the FIFO
    output vga_pkg::pixel_t data_out,
    output logic            h_sync,
    output logic            v_sync
);

    vga_pkg::pixel_t pixel_nxt;            // Pixel chosen for this tick

    // ==================================================
    // Pixel source
    // ==================================================
    always_comb begin
        if (de && fifo_empty) begin
            pixel_nxt = `VGA_UNDERRUN_COLOR;   // Visible area with no data
        end else if (de) begin
            pixel_nxt = data_in;               // Normal FIFO pixel
        end else begin
            pixel_nxt = `VGA_BLANK_COLOR;      // Porches and sync
        end
    end

    // ==================================================
    // Output registers
    // ==================================================
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            data_out <= `VGA_BLANK_COLOR;
            h_sync   <= h_polarity;        // Idle at the inactive level
            v_sync   <= v_polarity;
        end else if (enable) begin
            data_out <= pixel_nxt;         // One tick behind de
            h_sync   <= h_sync_raw;        // Syncs stay aligned with the pixel
            v_sync   <= v_sync_raw;
        end
    end

endmodule

// File: logic/pixel_coords.sv
`timescale 1ns/1ps

// Column and row counters for the visible raster
module pixel_coords (
    input  logic            clk,
    input  logic            rstn,
    input  logic            enable,        // Pixel tick
    input  logic            de,            // Active pixel in this tick
    input  logic            line_end,      // Last tick of a line
    input  logic            frame_end,     // Last tick of a frame
    output vga_pkg::coord_t x,             // Column of the current pixel
    output vga_pkg::coord_t y              // Row of the current line
);

    // ==================================================
    // Column counter
    // ==================================================
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            x <= '0;
        end else if (enable) begin
            if (line_end)  x <= '0;        // Line end lies in FRP, never with de
            else if (de)   x <= x + 1'b1;  // Advance per shown pixel
        end
    end

    // ==================================================
    // Row counter
    // ==================================================
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            y <= '0;
        end else if (enable) begin
            if (frame_end)     y <= '0;    // Wrap to the first line
            else if (line_end) y <= y + 1'b1;
        end
    end

endmodule

// File: logic/video_timing.sv
`timescale 1ns/1ps

// Horizontal and vertical timing built from two chained phase FSMs
module video_timing (
    input  logic             clk,
    input  logic             rstn,
    input  logic             enable,       // Pixel tick
    input  vga_pkg::timing_t h_sync_len,
    input  vga_pkg::timing_t h_back_len,
    input  vga_pkg::timing_t h_active_len,
    input  vga_pkg::timing_t h_front_len,
    input  vga_pkg::timing_t v_sync_len,   // Vertical lengths count lines
    input  vga_pkg::timing_t v_back_len,
    input  vga_pkg::timing_t v_active_len,
    input  vga_pkg::timing_t v_front_len,
    input  logic             h_polarity,   // 1 inverts the horizontal sync
    input  logic             v_polarity,   // 1 inverts the vertical sync
    output logic             de,           // Active area, also the FIFO read request
    output logic             line_end,     // Last pixel tick of a line
    output logic             frame_end,    // Last pixel tick of a frame
    output logic             h_sync_raw,   // Unregistered sync with polarity applied
    output logic             v_sync_raw
);

    logic h_active, v_active;              // Active levels per axis
    logic h_sync, v_sync;                  // Sync phases per axis
    logic h_stop;                          // One line done, ticks the vertical FSM

    // Horizontal axis counts pixel ticks
    line_fsm u_h_line (
        .clk        (clk),
        .rstn       (rstn),
        .enable     (enable),
        .sync_len   (h_sync_len),
        .back_len   (h_back_len),
        .active_len (h_active_len),
        .front_len  (h_front_len),
        .active     (h_active),
        .sync       (h_sync),
        .stop       (h_stop)
    );

    // Vertical axis counts completed lines
    line_fsm u_v_line (
        .clk        (clk),
        .rstn       (rstn),
        .enable     (h_stop),
        .sync_len   (v_sync_len),
        .back_len   (v_back_len),
        .active_len (v_active_len),
        .front_len  (v_front_len),
        .active     (v_active),
        .sync       (v_sync),
        .stop       (frame_end)            // Only possible together with h_stop
    );

    assign de         = h_active & v_active;
    assign line_end   = h_stop;
    assign h_sync_raw = h_sync ^ h_polarity;
    assign v_sync_raw = v_sync ^ v_polarity;

endmodule

// File: logic/line_fsm.sv
`timescale 1ns/1ps

// One timing axis as a Moore FSM over the four raster phases
module line_fsm (
    input  logic             clk,
    input  logic             rstn,
    input  logic             enable,       // Tick of this axis
    input  vga_pkg::timing_t sync_len,     // Length of SYN in ticks
    input  vga_pkg::timing_t back_len,     // Length of BCP in ticks
    input  vga_pkg::timing_t active_len,   // Length of ACT in ticks
    input  vga_pkg::timing_t front_len,    // Length of FRP in ticks
    output logic             active,       // High in ACT
    output logic             sync,         // High in SYN
    output logic             stop          // Last enabled tick of FRP
);

    vga_pkg::phase_e  phase;               // Current phase
    vga_pkg::phase_e  phase_nxt;           // Phase that follows the current one
    vga_pkg::timing_t cnt;                 // Ticks spent in the current phase
    vga_pkg::timing_t phase_len;           // Length of the current phase
    vga_pkg::timing_t last_cnt;            // Final count of the current phase
    logic             last;                // Counter sits on its final count

    // ==================================================
    // Phase length and successor
    // ==================================================
    always_comb begin
        case (phase)
            vga_pkg::SYN: phase_len = sync_len;
            vga_pkg::BCP: phase_len = back_len;
            vga_pkg::ACT: phase_len = active_len;
            default:      phase_len = front_len;
        endcase
    end

    always_comb begin
        case (phase)
            vga_pkg::SYN: phase_nxt = vga_pkg::BCP;
            vga_pkg::BCP: phase_nxt = vga_pkg::ACT;
            vga_pkg::ACT: phase_nxt = vga_pkg::FRP;
            default:      phase_nxt = vga_pkg::SYN;  // FRP wraps to a new period
        endcase
    end

    assign last_cnt = phase_len - 1'b1;    // Lengths are at least 1
    assign last     = (cnt == last_cnt);

    // ==================================================
    // State and phase counter
    // ==================================================
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            phase <= vga_pkg::SYN;
            cnt   <= '0;
        end else if (enable) begin         // Gaps in enable freeze everything
            if (last) begin
                phase <= phase_nxt;        // Move on and restart the count
                cnt   <= '0;
            end else begin
                cnt   <= cnt + 1'b1;
            end
        end
    end

    // Moore outputs plus the tick-qualified end marker
    assign active = (phase == vga_pkg::ACT);
    assign sync   = (phase == vga_pkg::SYN);
    assign stop   = enable & last & (phase == vga_pkg::FRP);

endmodule

// File: logic/vga_pkg.sv
`include "vga_cfg.svh"

package vga_pkg;

    // ==================================================
    // Vector types with a meaning
    // ==================================================
    typedef logic [`VGA_TIMING_W-1:0] timing_t;  // Phase length or phase counter
    typedef logic [`VGA_TIMING_W-1:0] coord_t;   // Pixel column or row
    typedef logic [`VGA_PIXEL_W-1:0]  pixel_t;   // RGB pixel

    // ==================================================
    // Phases of one timing axis
    // ==================================================
    // Order matches the raster sequence
    typedef enum logic [1:0] {
        SYN,                     // Sync pulse
        BCP,                     // Back porch
        ACT,                     // Active video
        FRP                      // Front porch
    } phase_e;

endpackage

// File: logic/vga_cfg.svh
`ifndef VGA_CFG_SVH
`define VGA_CFG_SVH

// ==================================================
// Project-wide widths
// ==================================================
`define VGA_TIMING_W 12          // Phase lengths, counters, coordinates
`define VGA_PIXEL_W  12          // RGB444 pixel

// ==================================================
// Fixed colours
// ==================================================
`define VGA_BLANK_COLOR    12'hFF0  // Yellow outside the active area
`define VGA_UNDERRUN_COLOR 12'hF0F  // Purple when the FIFO runs dry

`endif
